// ==== cache_geom_pkg.sv ====
`default_nettype none

package cache_geom_pkg;

   // Default geometry, overridable at the top level
   parameter int ADDR_W_DEF   = 16;  // Byte address width of the data space
   parameter int DATA_W_DEF   = 32;  // Host and memory word width
   parameter int NLINES_W_DEF = 4;   // log2 of the line count

   // Bytes per word and the byte-select bits dropped from word addresses
   parameter int NBYTES   = DATA_W_DEF / 8;
   parameter int NBYTES_W = $clog2(NBYTES);

endpackage

`default_nettype wire

// ==== cache_ctrl_pkg.sv ====
`default_nettype none

package cache_ctrl_pkg;

   // Sequencer states
   typedef enum logic [1:0] {
      IDLE   = 2'd0,  // Waiting for a data request
      LOOKUP = 2'd1,  // Tag compare on the registered address
      REFILL = 2'd2,  // Read miss, word fetch from memory
      WRITE  = 2'd3   // Write-through to memory
   } cache_state_e;

   // Word offsets inside the control space
   parameter int CTRL_ADDR_W = 3;

   typedef enum logic [CTRL_ADDR_W-1:0] {
      READ_HIT   = 3'd0,  // Counter
      READ_MISS  = 3'd1,  // Counter
      WRITE_HIT  = 3'd2,  // Counter
      WRITE_MISS = 3'd3,  // Counter
      WTB_EMPTY  = 3'd4,  // No back-end write pending
      INVALIDATE = 3'd5,  // Command, clears all valid bits
      CNT_RESET  = 3'd6   // Command, clears all counters
   } ctrl_reg_e;

endpackage

`default_nettype wire

// ==== cache_front_end.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_front_end #(
   parameter int ADDR_W = 16,
   parameter int DATA_W = 32
) (
   input  wire                                  clk,
   input  wire                                  rst,
   // Host port
   input  wire                                  req,
   input  wire [ADDR_W-cache_geom_pkg::NBYTES_W:0] addr,   // Top bit selects control space
   input  wire [DATA_W-1:0]                     wdata,
   input  wire [DATA_W/8-1:0]                   wstrb,
   output logic [DATA_W-1:0]                    rdata,
   output logic                                 ack,
   // Routed requests
   output logic                                 data_req,
   output logic                                 ctrl_req,
   // Held copy of the request
   output logic                                 req_reg,
   output logic [ADDR_W-cache_geom_pkg::NBYTES_W-1:0] addr_reg,
   output logic [DATA_W-1:0]                    wdata_reg,
   output logic [DATA_W/8-1:0]                  wstrb_reg,
   output logic [cache_ctrl_pkg::CTRL_ADDR_W-1:0] ctrl_addr,
   // Responses
   input  wire                                  data_ack,
   input  wire [DATA_W-1:0]                     data_rdata,
   input  wire                                  ctrl_ack,
   input  wire [DATA_W-1:0]                     ctrl_rdata
);

   localparam int WA_W = ADDR_W - cache_geom_pkg::NBYTES_W;  // Data space word address

   logic sel_reg;  // Held request targets control space
   logic ready;    // Free to take a new request

   // The ack cycle frees the slot, so the host may chain its next request
   assign ready = ~req_reg | ack;

   // Data path starts its lookup off the live request
   assign data_req = req & ready & ~addr[WA_W];

   assign ctrl_req  = req_reg & sel_reg;        // Control block sees the held copy
   assign ctrl_addr = addr_reg[cache_ctrl_pkg::CTRL_ADDR_W-1:0];

   // Response back to the host from the selected target
   assign ack   = sel_reg ? ctrl_ack : data_ack;
   assign rdata = sel_reg ? ctrl_rdata : data_rdata;

   always_ff @(posedge clk) begin
      if (rst) begin
         req_reg <= 1'b0;
         sel_reg <= 1'b0;
      end else if (ready) begin
         req_reg <= req;
         if (req)
            sel_reg <= addr[WA_W];
      end
   end

   // Payload held for the whole transaction
   always_ff @(posedge clk) begin
      if (ready && req) begin
         addr_reg  <= addr[WA_W-1:0];
         wdata_reg <= wdata;
         wstrb_reg <= wstrb;
      end
   end

endmodule

`default_nettype wire

// ==== cache_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_fsm #(
   parameter int ADDR_W   = 16,
   parameter int DATA_W   = 32,
   parameter int NLINES_W = 4
) (
   input  wire                        clk,
   input  wire                        rst,
   // From the front end
   input  wire                        data_req,
   input  wire                        req_reg,
   input  wire [ADDR_W-cache_geom_pkg::NBYTES_W-1:0] addr_reg,
   input  wire [DATA_W-1:0]           wdata_reg,
   input  wire [DATA_W/8-1:0]         wstrb_reg,
   output logic                       data_ack,
   output logic [DATA_W-1:0]          data_rdata,
   // Cache memory
   output logic [NLINES_W-1:0]        lookup_idx,
   output logic [ADDR_W-cache_geom_pkg::NBYTES_W-NLINES_W-1:0] tag_in,
   input  wire                        hit,
   input  wire [DATA_W-1:0]           hit_data,
   output logic                       fill_en,
   output logic [DATA_W-1:0]          fill_data,
   output logic                       wr_en,
   output logic [DATA_W/8-1:0]        wr_strb,
   output logic [DATA_W-1:0]          wr_data,
   // Back-end port
   output logic                       be_req,
   output logic [ADDR_W-cache_geom_pkg::NBYTES_W-1:0] be_addr,
   output logic [DATA_W-1:0]          be_wdata,
   output logic [DATA_W/8-1:0]        be_wstrb,
   input  wire [DATA_W-1:0]           be_rdata,
   input  wire                        be_ack,
   // Events for the controller
   output logic                       read_hit,
   output logic                       read_miss,
   output logic                       write_hit,
   output logic                       write_miss,
   output logic                       write_idle
);

   localparam int WA_W = ADDR_W - cache_geom_pkg::NBYTES_W;

   cache_ctrl_pkg::cache_state_e state;

   logic is_write;  // Any strobe bit set
   logic serve;     // Lookup cycle of a live request

   assign is_write = |wstrb_reg;
   assign serve    = (state == cache_ctrl_pkg::LOOKUP) && req_reg;

   // Index and tag straight off the held address
   assign lookup_idx = addr_reg[NLINES_W-1:0];
   assign tag_in     = addr_reg[WA_W-1:NLINES_W];

   // Refill lands with the memory answer
   assign fill_en   = (state == cache_ctrl_pkg::REFILL) && be_ack;
   assign fill_data = be_rdata;

   // Line update on a write hit, checked again in case of an invalidate
   assign wr_en   = (state == cache_ctrl_pkg::WRITE) && be_ack && hit;
   assign wr_strb = wstrb_reg;
   assign wr_data = wdata_reg;

   // One strobe per served request
   assign read_hit   = serve & ~is_write &  hit;
   assign read_miss  = serve & ~is_write & ~hit;
   assign write_hit  = serve &  is_write &  hit;
   assign write_miss = serve &  is_write & ~hit;

   assign write_idle = (state != cache_ctrl_pkg::WRITE);  // Low while a write waits on memory

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= cache_ctrl_pkg::IDLE;
         be_req   <= 1'b0;
         data_ack <= 1'b0;
      end else begin
         data_ack <= 1'b0;  // Single-cycle pulse
         case (state)
            cache_ctrl_pkg::IDLE:
               if (data_req)
                  state <= cache_ctrl_pkg::LOOKUP;
            cache_ctrl_pkg::LOOKUP: begin
               if (!req_reg) begin
                  state <= cache_ctrl_pkg::IDLE;
               end else if (is_write) begin
                  be_req <= 1'b1;                    // Write always goes through
                  state  <= cache_ctrl_pkg::WRITE;
               end else if (hit) begin
                  data_ack <= 1'b1;
                  state    <= cache_ctrl_pkg::IDLE;
               end else begin
                  be_req <= 1'b1;                    // Fetch the missing word
                  state  <= cache_ctrl_pkg::REFILL;
               end
            end
            cache_ctrl_pkg::REFILL,
            cache_ctrl_pkg::WRITE:
               if (be_ack) begin
                  be_req   <= 1'b0;
                  data_ack <= 1'b1;
                  state    <= cache_ctrl_pkg::IDLE;
               end
            default:
               state <= cache_ctrl_pkg::IDLE;
         endcase
      end
   end

   // Read data and back-end payload
   always_ff @(posedge clk) begin
      if (serve) begin
         be_addr  <= addr_reg;
         be_wdata <= wdata_reg;
         be_wstrb <= is_write ? wstrb_reg : '0;  // Zero strobe marks a read
         if (!is_write && hit)
            data_rdata <= hit_data;
      end else if (fill_en) begin
         data_rdata <= be_rdata;                 // Miss returns the memory word
      end
   end

endmodule

`default_nettype wire

// ==== cache_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_memory #(
   parameter int ADDR_W   = 16,
   parameter int DATA_W   = 32,
   parameter int NLINES_W = 4
) (
   input  wire                        clk,
   input  wire                        rst,
   input  wire                        invalidate,  // Clears every line
   // Lookup
   input  wire [NLINES_W-1:0]         lookup_idx,
   input  wire [ADDR_W-cache_geom_pkg::NBYTES_W-NLINES_W-1:0] tag_in,
   output logic                       hit,
   output logic [DATA_W-1:0]          hit_data,
   // Refill, whole word
   input  wire                        fill_en,
   input  wire [DATA_W-1:0]           fill_data,
   // Write hit, byte merge
   input  wire                        wr_en,
   input  wire [DATA_W/8-1:0]         wr_strb,
   input  wire [DATA_W-1:0]           wr_data
);

   localparam int NLINES = 2 ** NLINES_W;
   localparam int TAG_W  = ADDR_W - cache_geom_pkg::NBYTES_W - NLINES_W;
   localparam int NBYTES = DATA_W / 8;

   logic [TAG_W-1:0]  tag_mem  [NLINES];
   logic [DATA_W-1:0] data_mem [NLINES];
   logic [NLINES-1:0] valid;

   // Direct-mapped compare
   assign hit      = valid[lookup_idx] && (tag_mem[lookup_idx] == tag_in);
   assign hit_data = data_mem[lookup_idx];

   // Valid bits, invalidate wins over a fill in the same cycle
   always_ff @(posedge clk) begin
      if (rst || invalidate)
         valid <= '0;
      else if (fill_en)
         valid[lookup_idx] <= 1'b1;
   end

   always_ff @(posedge clk) begin
      if (fill_en) begin
         tag_mem[lookup_idx]  <= tag_in;
         data_mem[lookup_idx] <= fill_data;
      end else if (wr_en) begin
         for (int b = 0; b < NBYTES; b++) begin
            if (wr_strb[b])
               data_mem[lookup_idx][8*b +: 8] <= wr_data[8*b +: 8];  // Only strobed bytes
         end
      end
   end

endmodule

`default_nettype wire

// ==== cache_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_control #(
   parameter int DATA_W = 32
) (
   input  wire                                  clk,
   input  wire                                  rst,
   // Control space access
   input  wire                                  ctrl_req,
   input  wire [cache_ctrl_pkg::CTRL_ADDR_W-1:0] ctrl_addr,
   output logic                                 ctrl_ack,
   output logic [DATA_W-1:0]                    ctrl_rdata,
   // Events from the sequencer
   input  wire                                  read_hit,
   input  wire                                  read_miss,
   input  wire                                  write_hit,
   input  wire                                  write_miss,
   input  wire                                  write_idle,
   output logic                                 invalidate
);

   cache_ctrl_pkg::ctrl_reg_e offset;

   logic              access;      // First cycle of a held request
   logic [3:0]        inc;         // Counter increments, in offset order
   logic [DATA_W-1:0] cnt [4];     // Hit and miss counters

   assign offset = cache_ctrl_pkg::ctrl_reg_e'(ctrl_addr);
   assign access = ctrl_req & ~ctrl_ack;  // Request stays high through the ack cycle
   assign inc    = {write_miss, write_hit, read_miss, read_hit};

   always_ff @(posedge clk) begin
      if (rst) begin
         ctrl_ack   <= 1'b0;
         invalidate <= 1'b0;
         for (int i = 0; i < 4; i++)
            cnt[i] <= '0;
      end else begin
         ctrl_ack   <= access;
         // Command offsets act on any access to them
         invalidate <= access && (offset == cache_ctrl_pkg::INVALIDATE);
         for (int i = 0; i < 4; i++) begin
            if (access && (offset == cache_ctrl_pkg::CNT_RESET))
               cnt[i] <= '0;
            else if (inc[i] && (cnt[i] != '1))
               cnt[i] <= cnt[i] + 1'b1;  // Saturate at all ones
         end
      end
   end

   // Register read mux
   always_ff @(posedge clk) begin
      if (access) begin
         case (offset)
            cache_ctrl_pkg::READ_HIT:   ctrl_rdata <= cnt[0];
            cache_ctrl_pkg::READ_MISS:  ctrl_rdata <= cnt[1];
            cache_ctrl_pkg::WRITE_HIT:  ctrl_rdata <= cnt[2];
            cache_ctrl_pkg::WRITE_MISS: ctrl_rdata <= cnt[3];
            cache_ctrl_pkg::WTB_EMPTY:  ctrl_rdata <= {{(DATA_W-1){1'b0}}, write_idle};
            default:                    ctrl_rdata <= '0;  // Commands read back zero
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== wt_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module wt_cache #(
   parameter int ADDR_W   = cache_geom_pkg::ADDR_W_DEF,
   parameter int DATA_W   = cache_geom_pkg::DATA_W_DEF,
   parameter int NLINES_W = cache_geom_pkg::NLINES_W_DEF
) (
   input  wire                        clk,
   input  wire                        rst,
   // Host port
   input  wire                        req,
   input  wire [ADDR_W-cache_geom_pkg::NBYTES_W:0] addr,
   input  wire [DATA_W-1:0]           wdata,
   input  wire [DATA_W/8-1:0]         wstrb,
   output logic [DATA_W-1:0]          rdata,
   output logic                       ack,
   // Memory port
   output logic                       be_req,
   output logic [ADDR_W-cache_geom_pkg::NBYTES_W-1:0] be_addr,
   output logic [DATA_W-1:0]          be_wdata,
   output logic [DATA_W/8-1:0]        be_wstrb,
   input  wire [DATA_W-1:0]           be_rdata,
   input  wire                        be_ack,
   // Chain to neighboring caches
   input  wire                        invalidate_in,
   output logic                       invalidate_out,
   input  wire                        wtb_empty_in,
   output logic                       wtb_empty_out
);

   localparam int WA_W  = ADDR_W - cache_geom_pkg::NBYTES_W;
   localparam int TAG_W = WA_W - NLINES_W;

   logic                   data_req, data_ack, ctrl_req, ctrl_ack, req_reg;
   logic [WA_W-1:0]        addr_reg;
   logic [DATA_W-1:0]      wdata_reg, data_rdata, ctrl_rdata;
   logic [DATA_W/8-1:0]    wstrb_reg;
   logic [cache_ctrl_pkg::CTRL_ADDR_W-1:0] ctrl_addr;
   logic [NLINES_W-1:0]    lookup_idx;
   logic [TAG_W-1:0]       tag_in;
   logic                   hit, fill_en, wr_en;
   logic [DATA_W-1:0]      hit_data, fill_data, wr_data;
   logic [DATA_W/8-1:0]    wr_strb;
   logic                   read_hit, read_miss, write_hit, write_miss, write_idle;
   logic                   invalidate;

   assign invalidate_out = invalidate | invalidate_in;  // Local or upstream flush
   assign wtb_empty_out  = write_idle & wtb_empty_in;

   cache_front_end #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_front_end (
      .clk, .rst, .req, .addr, .wdata, .wstrb, .rdata, .ack,
      .data_req, .ctrl_req, .req_reg, .addr_reg, .wdata_reg, .wstrb_reg, .ctrl_addr,
      .data_ack, .data_rdata, .ctrl_ack, .ctrl_rdata
   );

   cache_fsm #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .NLINES_W(NLINES_W)) u_fsm (
      .clk, .rst, .data_req, .req_reg, .addr_reg, .wdata_reg, .wstrb_reg,
      .data_ack, .data_rdata,
      .lookup_idx, .tag_in, .hit, .hit_data,
      .fill_en, .fill_data, .wr_en, .wr_strb, .wr_data,
      .be_req, .be_addr, .be_wdata, .be_wstrb, .be_rdata, .be_ack,
      .read_hit, .read_miss, .write_hit, .write_miss, .write_idle
   );

   cache_memory #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .NLINES_W(NLINES_W)) u_memory (
      .clk, .rst,
      .invalidate (invalidate_out),  // Chain flush reaches the arrays too
      .lookup_idx, .tag_in, .hit, .hit_data,
      .fill_en, .fill_data, .wr_en, .wr_strb, .wr_data
   );

   cache_control #(.DATA_W(DATA_W)) u_control (
      .clk, .rst, .ctrl_req, .ctrl_addr, .ctrl_ack, .ctrl_rdata,
      .read_hit, .read_miss, .write_hit, .write_miss, .write_idle,
      .invalidate
   );

endmodule

`default_nettype wire

// ==== wt_cache_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module wt_cache_chk #(
   parameter int ADDR_W = 16,
   parameter int DATA_W = 32
) (
   input wire                                        clk,
   input wire                                        rst,
   input wire                                        ack,
   input wire                                        be_req,
   input wire                                        be_ack,
   input wire [ADDR_W-cache_geom_pkg::NBYTES_W-1:0]  be_addr,
   input wire [DATA_W-1:0]                           be_wdata,
   input wire [DATA_W/8-1:0]                         be_wstrb,
   input wire [3:0]                                  strobes,  // Hit and miss events
   input wire cache_ctrl_pkg::cache_state_e          state
);

   // Back-end request frozen until memory answers
   be_hold: assert property (@(posedge clk) disable iff (rst)
      be_req && !be_ack |=> be_req && $stable(be_addr) && $stable(be_wdata)
                            && $stable(be_wstrb))
      else $error("back-end request or payload moved before be_ack");

   ack_pulse: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
      else $error("host ack held longer than one cycle");

   // One served request at a time, so an event is never followed by another
   one_event: assert property (@(posedge clk) disable iff (rst)
      (|strobes) |=> (strobes == 4'b0000))
      else $error("more than one event strobe for a single request");

   reset_idle: assert property (@(posedge clk)
      rst |=> state == cache_ctrl_pkg::IDLE && !ack && !be_req)
      else $error("sequencer not idle after reset");

endmodule

bind wt_cache wt_cache_chk #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_chk (
   .clk, .rst, .ack, .be_req, .be_ack, .be_addr, .be_wdata, .be_wstrb,
   .strobes ({read_hit, read_miss, write_hit, write_miss}),
   .state   (u_fsm.state)
);

`default_nettype wire

// ==== wt_cache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module wt_cache_tb;

   localparam int ADDR_W   = cache_geom_pkg::ADDR_W_DEF;
   localparam int DATA_W   = cache_geom_pkg::DATA_W_DEF;
   localparam int NLINES_W = cache_geom_pkg::NLINES_W_DEF;
   localparam int NB       = DATA_W / 8;
   localparam int WA_W     = ADDR_W - cache_geom_pkg::NBYTES_W;  // Word address bits
   localparam int NOPS     = 25;
   localparam int TIMEOUT  = 40;  // Cycles allowed for any ack

   // Table operation codes
   localparam logic [2:0] OP_RD    = 3'd0;
   localparam logic [2:0] OP_WR    = 3'd1;
   localparam logic [2:0] OP_CR    = 3'd2;  // Control space read
   localparam logic [2:0] OP_CW    = 3'd3;  // Control space command
   localparam logic [2:0] OP_CHAIN = 3'd4;  // Chain pins, no host access

   typedef struct packed {
      logic [2:0]        op;
      logic [WA_W-1:0]   addr;     // Word address or control offset
      logic [DATA_W-1:0] wdata;
      logic [NB-1:0]     wstrb;
      logic              exp_hit;  // Expected hit, seen on reads as no memory fetch
   } op_t;

   logic                clk, rst, req, ack;
   logic [WA_W:0]       addr;
   logic [DATA_W-1:0]   wdata, rdata;
   logic [NB-1:0]       wstrb;
   logic                be_req, be_ack;
   logic [WA_W-1:0]     be_addr;
   logic [DATA_W-1:0]   be_wdata, be_rdata;
   logic [NB-1:0]       be_wstrb;
   logic                invalidate_in, invalidate_out, wtb_empty_in, wtb_empty_out;

   op_t                 ops [NOPS];
   logic [DATA_W-1:0]   mem [2**WA_W];                  // Memory model
   logic [2**NLINES_W-1:0]   vld;                        // Reference valid bits
   logic [WA_W-NLINES_W-1:0] tags [2**NLINES_W];
   logic [DATA_W-1:0]   n_rh, n_rm, n_wh, n_wm;         // Event tallies
   logic [31:0]         lfsr = 32'ha318ed6f;
   int                  be_count = 0;                   // Back-end requests seen

   wt_cache #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .NLINES_W(NLINES_W)) u_wt_cache (
      .clk, .rst, .req, .addr, .wdata, .wstrb, .rdata, .ack,
      .be_req, .be_addr, .be_wdata, .be_wstrb, .be_rdata, .be_ack,
      .invalidate_in, .invalidate_out, .wtb_empty_in, .wtb_empty_out
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;  // 8 ns
   end

   function automatic logic [31:0] galois_step(input logic [31:0] s);
      return s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1;  // Taps 32 22 2 1
   endfunction

   // Initial memory contents, every address bit shows up
   function automatic logic [DATA_W-1:0] fill_word(input logic [WA_W-1:0] a);
      return DATA_W'({~a, a, a}) ^ 32'h5a3c_96e1;
   endfunction

   function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old,
                                                     input logic [DATA_W-1:0] wd,
                                                     input logic [NB-1:0] strb);
      logic [DATA_W-1:0] res;
      res = old;
      for (int b = 0; b < NB; b++) begin
         if (strb[b])
            res[8*b +: 8] = wd[8*b +: 8];
      end
      return res;
   endfunction

   function automatic op_t entry(input logic [2:0] op, input logic [WA_W-1:0] a,
                                 input logic [DATA_W-1:0] wd, input logic [NB-1:0] st,
                                 input logic h);
      return {op, a, wd, st, h};
   endfunction

   // Register value the control space should return
   function automatic logic [DATA_W-1:0] ctrl_expect(input logic [2:0] off);
      case (cache_ctrl_pkg::ctrl_reg_e'(off))
         cache_ctrl_pkg::READ_HIT:   return n_rh;
         cache_ctrl_pkg::READ_MISS:  return n_rm;
         cache_ctrl_pkg::WRITE_HIT:  return n_wh;
         cache_ctrl_pkg::WRITE_MISS: return n_wm;
         cache_ctrl_pkg::WTB_EMPTY:  return 1;   // Nothing pending between requests
         default:                    return '0;  // Commands
      endcase
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Some tests failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_data(input logic [DATA_W-1:0] act, input logic [DATA_W-1:0] exp,
                             input string name);
      if (act !== exp)
         abort_run($sformatf("[FAIL] %0t %s: got %h, expected %h", $time, name, act, exp));
   endtask

   task automatic check_bit(input logic act, input logic exp, input string name);
      if (act !== exp)
         abort_run($sformatf("[FAIL] %0t %s: got %b, expected %b", $time, name, act, exp));
   endtask

   // Chain pins with the cache idle
   task automatic chain_test();
      @(negedge clk);
      invalidate_in = 1'b1;
      @(negedge clk);
      check_bit(invalidate_out, 1'b1, "invalidate_out");
      invalidate_in = 1'b0;
      wtb_empty_in  = 1'b0;
      @(negedge clk);
      check_bit(invalidate_out, 1'b0, "invalidate_out");
      check_bit(wtb_empty_out, 1'b0, "wtb_empty_out");
      wtb_empty_in = 1'b1;
      @(negedge clk);
      check_bit(wtb_empty_out, 1'b1, "wtb_empty_out");
      vld = '0;  // Flushed by the pulse
   endtask

   task automatic run_op(input op_t e);
      logic [NLINES_W-1:0] idx;
      logic                model_hit;
      logic [DATA_W-1:0]   exp_data;
      int                  cycles;
      int                  be_before;
      idx       = e.addr[NLINES_W-1:0];
      model_hit = vld[idx] && (tags[idx] == e.addr[WA_W-1:NLINES_W]);
      case (e.op)
         OP_RD:   exp_data = mem[e.addr];
         OP_WR:   exp_data = merge_bytes(mem[e.addr], e.wdata, e.wstrb);
         OP_CR:   exp_data = ctrl_expect(e.addr[2:0]);
         default: exp_data = '0;
      endcase
      @(negedge clk);
      req       = 1'b1;
      addr      = {(e.op == OP_CR || e.op == OP_CW), e.addr};  // Top bit picks control
      wdata     = e.wdata;
      wstrb     = e.wstrb;
      be_before = be_count;
      cycles    = 0;
      do begin
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT)
            abort_run("the cache gave no ack within the timeout");
      end while (!ack);
      case (e.op)
         OP_RD: begin
            check_data(rdata, exp_data, "rdata");
            check_bit(be_count == be_before, e.exp_hit, "read hit");  // Hit needs no fetch
            if (model_hit) begin
               check_data(cycles, 2, "ack latency");
               n_rh++;
            end else begin
               vld[idx]  = 1'b1;             // Refill allocates
               tags[idx] = e.addr[WA_W-1:NLINES_W];
               n_rm++;
            end
         end
         OP_WR: begin
            check_data(mem[e.addr], exp_data, "memory word");
            check_data(be_count - be_before, 1, "be_req count");
            if (model_hit)
               n_wh++;
            else
               n_wm++;                       // No allocate
         end
         OP_CR: begin
            check_data(rdata, exp_data, "ctrl rdata");
            check_data(cycles, 2, "ack latency");
         end
         default: begin
            check_data(cycles, 2, "ack latency");
            if (e.addr[2:0] == cache_ctrl_pkg::INVALIDATE) begin
               check_bit(invalidate_out, 1'b1, "invalidate_out");
               vld = '0;
            end else if (e.addr[2:0] == cache_ctrl_pkg::CNT_RESET) begin
               n_rh = '0;
               n_rm = '0;
               n_wh = '0;
               n_wm = '0;
            end
         end
      endcase
      req   = 1'b0;
      wstrb = '0;
   endtask

   task automatic load_table();
      ops[0]  = entry(OP_RD, 12'h012, 0, 4'h0, 1'b0);            // Cold miss
      ops[1]  = entry(OP_RD, 12'h012, 0, 4'h0, 1'b1);
      ops[2]  = entry(OP_WR, 12'h012, 32'hdead_beef, 4'b0101, 1'b1);
      ops[3]  = entry(OP_RD, 12'h012, 0, 4'h0, 1'b1);            // Merged bytes
      ops[4]  = entry(OP_WR, 12'h034, 32'h1234_5678, 4'hf, 1'b0);
      ops[5]  = entry(OP_RD, 12'h034, 0, 4'h0, 1'b0);            // No allocate on write
      ops[6]  = entry(OP_RD, 12'h112, 0, 4'h0, 1'b0);            // Same index, evicts
      ops[7]  = entry(OP_RD, 12'h012, 0, 4'h0, 1'b0);
      ops[8]  = entry(OP_CR, cache_ctrl_pkg::READ_HIT, 0, 4'h0, 1'b0);
      ops[9]  = entry(OP_CR, cache_ctrl_pkg::READ_MISS, 0, 4'h0, 1'b0);
      ops[10] = entry(OP_CR, cache_ctrl_pkg::WRITE_HIT, 0, 4'h0, 1'b0);
      ops[11] = entry(OP_CR, cache_ctrl_pkg::WRITE_MISS, 0, 4'h0, 1'b0);
      ops[12] = entry(OP_CR, cache_ctrl_pkg::WTB_EMPTY, 0, 4'h0, 1'b0);
      ops[13] = entry(OP_CW, cache_ctrl_pkg::CNT_RESET, 0, 4'hf, 1'b0);
      ops[14] = entry(OP_CR, cache_ctrl_pkg::READ_MISS, 0, 4'h0, 1'b0);
      ops[15] = entry(OP_CW, cache_ctrl_pkg::INVALIDATE, 0, 4'hf, 1'b0);
      ops[16] = entry(OP_RD, 12'h012, 0, 4'h0, 1'b0);            // Flushed line
      ops[17] = entry(OP_WR, 12'h012, 32'ha5c3_0f96, 4'b1000, 1'b1);
      ops[18] = entry(OP_RD, 12'h012, 0, 4'h0, 1'b1);
      ops[19] = entry(OP_CR, cache_ctrl_pkg::WRITE_HIT, 0, 4'h0, 1'b0);
      ops[20] = entry(OP_CHAIN, 12'h000, 0, 4'h0, 1'b0);
      ops[21] = entry(OP_RD, 12'h012, 0, 4'h0, 1'b0);            // Upstream flush
      ops[22] = entry(OP_RD, 12'h034, 0, 4'h0, 1'b0);
      ops[23] = entry(OP_RD, 12'h034, 0, 4'h0, 1'b1);
      ops[24] = entry(OP_CR, cache_ctrl_pkg::READ_MISS, 0, 4'h0, 1'b0);
   endtask

   // Memory model, answers after 0 to 3 cycles
   initial begin : memory_model
      logic [1:0] lag;
      be_ack   = 1'b0;
      be_rdata = '0;
      forever begin
         @(negedge clk);
         be_ack = 1'b0;
         if (!rst && be_req) begin
            be_count++;
            for (int k = 0; k < 2; k++) begin
               lag[k] = lfsr[0];
               lfsr   = galois_step(lfsr);  // One step per bit
            end
            for (int w = 0; w <= lag; w++) begin
               if (w > 0)
                  @(negedge clk);
               if (be_wstrb != '0)
                  check_bit(wtb_empty_out, 1'b0, "wtb_empty_out");  // Write pending
            end
            if (be_wstrb != '0)
               mem[be_addr] = merge_bytes(mem[be_addr], be_wdata, be_wstrb);
            be_rdata = mem[be_addr];
            be_ack   = 1'b1;
         end
      end
   end

   initial begin
      rst           = 1'b1;
      req           = 1'b0;
      addr          = '0;
      wdata         = '0;
      wstrb         = '0;
      invalidate_in = 1'b0;
      wtb_empty_in  = 1'b1;
      vld           = '0;
      n_rh          = '0;
      n_rm          = '0;
      n_wh          = '0;
      n_wm          = '0;
      for (int i = 0; i < 2**WA_W; i++)
         mem[i] = fill_word(WA_W'(i));
      load_table();
      repeat (8) @(negedge clk);
      rst = 1'b0;
      for (int i = 0; i < NOPS; i++) begin
         if (ops[i].op == OP_CHAIN)
            chain_test();
         else
            run_op(ops[i]);
      end
      $display("All tests passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== wt_cache.f ====
cache_geom_pkg.sv
cache_ctrl_pkg.sv
cache_front_end.sv
cache_fsm.sv
cache_memory.sv
cache_control.sv
wt_cache.sv
wt_cache_chk.sv
wt_cache_tb.sv
